// File: hw/cnn_class_pkg.sv
`include "cnn_consts.svh"

package cnn_class_pkg;

    // Index of the winning class
    typedef logic [$clog2(`ST3_CO)-1:0] class_idx_t;

    // ASCII letter of the class
    typedef logic [7:0] letter_t;

    // One-hot LED code, class 0 on the MSB
    typedef logic [`ST3_CO-1:0] led_t;

    typedef struct packed {
        letter_t letter;
        led_t    led;
    } class_result_t;

endpackage

// File: hw/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Feature map geometry
////////////////////////////////////////////////////////////////////////////

// Channels per pixel
`define ST3_CI      3
// Map width and height in pixels
`define ST3_MAP_W   4
`define ST3_MAP_H   4
// Pooled positions in one frame
`define ST3_POS     4
// Output classes
`define ST3_CO      3

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////

// Unsigned ReLU activation
`define ST3_IF_BW   8
// Unsigned sum of all channels, 3 x 255 fits
`define ST3_ACC_BW  10
// Signed weight
`define ST3_W_BW    4
// Signed class score
`define ST3_OUT_BW  16

`endif

// File: hw/cnn_data_pkg.sv
`include "cnn_consts.svh"

package cnn_data_pkg;

    // One channel value
    typedef logic [`ST3_IF_BW-1:0] chan_t;

    // All channels of one pixel, input beat and pooled beat alike
    typedef struct packed {
        chan_t [`ST3_CI-1:0] ch;
    } pixel_vec_t;

    // Channel sum of one pooled pixel
    typedef logic [`ST3_ACC_BW-1:0] acc_t;

    typedef logic signed [`ST3_W_BW-1:0] weight_t;
    typedef logic signed [`ST3_OUT_BW-1:0] score_t;

    // One score per class, class 0 at index 0
    typedef score_t [`ST3_CO-1:0] score_vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fully connected weights
    ////////////////////////////////////////////////////////////////////////////

    // Row = class, column = pooled position in raster order
    localparam weight_t WEIGHT_TABLE [`ST3_CO][`ST3_POS] = '{
        '{ 4'sd3, -4'sd1,  4'sd1, -4'sd2},
        '{-4'sd1,  4'sd4,  4'sd0,  4'sd1},
        '{ 4'sd1, -4'sd2, -4'sd3,  4'sd5}
    };

endpackage

// File: hw/stage3_cnn_acc_ci.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module stage3_cnn_acc_ci (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_in_valid,
    input  cnn_data_pkg::pixel_vec_t i_in_pool,
    output logic                     o_acc_valid,
    output cnn_data_pkg::acc_t       o_acc
);

    cnn_data_pkg::acc_t ch_sum;

    // Sum over channels, widened before adding
    always_comb begin
        ch_sum = '0;
        for (int c = 0; c < `ST3_CI; c++) begin
            ch_sum = ch_sum + cnn_data_pkg::acc_t'(i_in_pool.ch[c]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            o_acc <= ch_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_acc_valid <= 1'b0;
        end else begin
            o_acc_valid <= i_in_valid;
        end
    end

endmodule

// File: hw/stage3_cnn_core.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module stage3_cnn_core (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_in_valid,
    input  cnn_data_pkg::acc_t       i_in_acc,
    output logic                     o_core_valid,
    output cnn_data_pkg::score_vec_t o_score
);

    localparam int POS_W = $clog2(`ST3_POS);

    logic [POS_W-1:0]         pos;
    logic                     last_pos;
    cnn_data_pkg::score_vec_t run_sum;
    cnn_data_pkg::score_vec_t sum_next;

    assign last_pos = (pos == POS_W'(`ST3_POS - 1));

    // Multiply-accumulate for every class at the current position
    always_comb begin
        for (int c = 0; c < `ST3_CO; c++) begin
            // Zero-extend so the unsigned sum stays positive in signed math
            sum_next[c] = run_sum[c]
                        + $signed({1'b0, i_in_acc}) * cnn_data_pkg::WEIGHT_TABLE[c][pos];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Position counter and running sums
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pos          <= '0;
            run_sum      <= '0;
            o_core_valid <= 1'b0;
        end else begin
            o_core_valid <= i_in_valid & last_pos;
            if (i_in_valid) begin
                if (last_pos) begin
                    // Next frame may start on the following cycle
                    pos     <= '0;
                    run_sum <= '0;
                end else begin
                    pos     <= pos + 1'b1;
                    run_sum <= sum_next;
                end
            end
        end
    end

    // Finished scores
    always_ff @(posedge clk) begin
        if (i_in_valid && last_pos) begin
            o_score <= sum_next;
        end
    end

endmodule

// File: hw/stage3_compare_alpha.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module stage3_compare_alpha (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_in_valid,
    input  cnn_data_pkg::score_vec_t    i_in_score,
    output logic                        o_valid,
    output cnn_class_pkg::class_result_t o_result
);

    cnn_data_pkg::score_vec_t score_q;
    logic                     valid_q;
    cnn_class_pkg::class_idx_t best;

    // Zero scores after reset, so class a shows
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            score_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_in_valid;
            if (i_in_valid) begin
                score_q <= i_in_score;
            end
        end
    end

    // Argmax, strict compare keeps the lowest index on a tie
    always_comb begin
        best = '0;
        for (int c = 1; c < `ST3_CO; c++) begin
            if (score_q[c] > score_q[best]) begin
                best = cnn_class_pkg::class_idx_t'(c);
            end
        end
    end

    // Letter a, b, c and one-hot LED from the MSB down
    assign o_result.letter = "a" + cnn_class_pkg::letter_t'(best);
    assign o_result.led    = cnn_class_pkg::led_t'(1 << (`ST3_CO - 1)) >> best;
    assign o_valid         = valid_q;

endmodule

// File: hw/stage3_max_pooling.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module stage3_max_pooling (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_relu_valid,
    input  cnn_data_pkg::pixel_vec_t i_relu,
    output logic                     o_pool_valid,
    output cnn_data_pkg::pixel_vec_t o_pool
);

    localparam int COL_W  = $clog2(`ST3_MAP_W);
    localparam int ROW_W  = $clog2(`ST3_MAP_H);
    localparam int HALF_W = `ST3_MAP_W / 2;

    logic [COL_W-1:0]         col;
    logic [ROW_W-1:0]         row;
    logic                     win_done;
    cnn_data_pkg::pixel_vec_t left_pix;
    cnn_data_pkg::pixel_vec_t pair_max;
    cnn_data_pkg::pixel_vec_t half_buf [HALF_W];

    // Channel-wise maximum of two pixels
    function automatic cnn_data_pkg::pixel_vec_t pix_max(
        input cnn_data_pkg::pixel_vec_t a,
        input cnn_data_pkg::pixel_vec_t b
    );
        cnn_data_pkg::pixel_vec_t m;
        for (int c = 0; c < `ST3_CI; c++) begin
            m.ch[c] = (a.ch[c] > b.ch[c]) ? a.ch[c] : b.ch[c];
        end
        return m;
    endfunction

    // Horizontal pair max, left pixel held from the even column
    assign pair_max = pix_max(left_pix, i_relu);

    // Bottom-right pixel of a 2x2 window
    assign win_done = i_relu_valid & col[0] & row[0];

    ////////////////////////////////////////////////////////////////////////////
    // Raster position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_relu_valid) begin
            if (col == COL_W'(`ST3_MAP_W - 1)) begin
                col <= '0;
                // Wrap at frame end
                row <= (row == ROW_W'(`ST3_MAP_H - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Half-row buffer and window max
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_relu_valid) begin
            if (!col[0]) begin
                left_pix <= i_relu;
            end else if (!row[0]) begin
                // Top half of the window, kept for the next row
                half_buf[col[COL_W-1:1]] <= pair_max;
            end
        end
        if (win_done) begin
            o_pool <= pix_max(pair_max, half_buf[col[COL_W-1:1]]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_pool_valid <= 1'b0;
        end else begin
            o_pool_valid <= win_done;
        end
    end

endmodule

// File: hw/stage3_top_cnn.sv
`timescale 1ns/1ps

module stage3_top_cnn (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_relu_valid,
    input  cnn_data_pkg::pixel_vec_t     i_relu,
    output logic                         o_valid,
    output cnn_class_pkg::class_result_t o_result
);

    logic                     pool_valid;
    cnn_data_pkg::pixel_vec_t pool;
    logic                     acc_valid;
    cnn_data_pkg::acc_t       acc;
    logic                     core_valid;
    cnn_data_pkg::score_vec_t score;

    // Pooling, channel sum, FC layer, argmax
    stage3_max_pooling u_max_pooling (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_relu_valid (i_relu_valid),
        .i_relu       (i_relu),
        .o_pool_valid (pool_valid),
        .o_pool       (pool)
    );

    stage3_cnn_acc_ci u_cnn_acc_ci (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (pool_valid),
        .i_in_pool   (pool),
        .o_acc_valid (acc_valid),
        .o_acc       (acc)
    );

    stage3_cnn_core u_cnn_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (acc_valid),
        .i_in_acc     (acc),
        .o_core_valid (core_valid),
        .o_score      (score)
    );

    stage3_compare_alpha u_compare_alpha (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (core_valid),
        .i_in_score (score),
        .o_valid    (o_valid),
        .o_result   (o_result)
    );

endmodule

// File: sim.f
+incdir+hw
hw/cnn_data_pkg.sv
hw/cnn_class_pkg.sv
hw/stage3_max_pooling.sv
hw/stage3_cnn_acc_ci.sv
hw/stage3_cnn_core.sv
hw/stage3_compare_alpha.sv
hw/stage3_top_cnn.sv
verif/tb_checker.sv
verif/tb_stage3_top.sv

// File: verif/tb_checker.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module tb_checker (
    input logic                         clk,
    input logic                         reset_n,
    input logic                         i_relu_valid,
    input cnn_data_pkg::pixel_vec_t     i_relu,
    input logic                         i_dut_valid,
    input cnn_class_pkg::class_result_t i_dut_result
);

    localparam int BEATS   = `ST3_MAP_W * `ST3_MAP_H;
    localparam int PW      = `ST3_MAP_W / 2;
    localparam int LATENCY = 4;

    // Class a shown while reset holds the scores at zero
    localparam logic [7:0]         RESET_LETTER = 8'h61;
    localparam logic [`ST3_CO-1:0] RESET_LED    = 3'b100;

    // Reference weights indexed by class and pooled position
    int w_model [`ST3_CO][`ST3_POS] = '{
        '{ 3, -1,  1, -2},
        '{-1,  4,  0,  1},
        '{ 1, -2, -3,  5}
    };

    cnn_data_pkg::pixel_vec_t     frame [BEATS];
    cnn_class_pkg::class_result_t exp_q [$];
    longint                       last_beat_q [$];
    longint cycle        = 0;
    int     beat         = 0;
    int     outstanding  = 0;
    int     err_count    = 0;
    int     result_count = 0;
    int     err_mark     = 0;
    int     result_mark  = 0;
    int     test_pass    = 0;
    int     test_fail    = 0;

    // Pool, channel sum, FC layer and argmax over the stored frame
    function automatic cnn_class_pkg::class_result_t predict();
        int score [`ST3_CO];
        int pooled;
        int m;
        int idx;
        int best;
        cnn_class_pkg::class_result_t r;
        for (int c = 0; c < `ST3_CO; c++) begin
            score[c] = 0;
        end
        for (int p = 0; p < `ST3_POS; p++) begin
            pooled = 0;
            for (int ch = 0; ch < `ST3_CI; ch++) begin
                m = 0;
                for (int k = 0; k < 4; k++) begin
                    idx = (2 * (p / PW) + k / 2) * `ST3_MAP_W + 2 * (p % PW) + k % 2;
                    if (frame[idx].ch[ch] > m) begin
                        m = frame[idx].ch[ch];
                    end
                end
                pooled += m;
            end
            for (int c = 0; c < `ST3_CO; c++) begin
                score[c] += pooled * w_model[c][p];
            end
        end
        // Lowest index wins a tie
        best = 0;
        for (int c = 1; c < `ST3_CO; c++) begin
            if (score[c] > score[best]) begin
                best = c;
            end
        end
        r.letter = 8'h61 + best;
        r.led = '0;
        r.led[`ST3_CO - 1 - best] = 1'b1;
        return r;
    endfunction

    task automatic check_result();
        cnn_class_pkg::class_result_t exp;
        longint t;
        if (exp_q.size() == 0) begin
            $display("o_valid went high at cycle %0d with no frame outstanding", cycle);
            err_count++;
        end else begin
            exp = exp_q.pop_front();
            t = last_beat_q.pop_front();
            result_count++;
            if (i_dut_result.letter !== exp.letter) begin
                $display("[ERROR] o_result.letter: got 0x%02h, expected 0x%02h",
                         i_dut_result.letter, exp.letter);
                err_count++;
            end
            if (i_dut_result.led !== exp.led) begin
                $display("[ERROR] o_result.led: got 0x%01h, expected 0x%01h",
                         i_dut_result.led, exp.led);
                err_count++;
            end
            if (cycle - t != LATENCY) begin
                $display("o_valid came %0d cycles after the last beat instead of %0d",
                         cycle - t, LATENCY);
                err_count++;
            end
        end
    endtask

    task automatic check_reset_result();
        if (i_dut_result.letter !== RESET_LETTER) begin
            $display("[ERROR] o_result.letter in reset: got 0x%02h, expected 0x%02h",
                     i_dut_result.letter, RESET_LETTER);
            err_count++;
        end
        if (i_dut_result.led !== RESET_LED) begin
            $display("[ERROR] o_result.led in reset: got 0x%01h, expected 0x%01h",
                     i_dut_result.led, RESET_LED);
            err_count++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!reset_n) begin
            if (i_dut_valid) begin
                $display("o_valid was high during reset at cycle %0d", cycle);
                err_count++;
            end
            // Reset has acted on the score register by the second edge
            if (cycle > 1) begin
                check_reset_result();
            end
            // Frames cut by reset never produce a result
            exp_q.delete();
            last_beat_q.delete();
            beat = 0;
        end else begin
            if (i_relu_valid) begin
                frame[beat] = i_relu;
                if (beat == BEATS - 1) begin
                    exp_q.push_back(predict());
                    last_beat_q.push_back(cycle);
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            if (i_dut_valid) begin
                check_result();
            end
        end
        outstanding = exp_q.size();
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    // One line per finished test
    task automatic end_test(input string name, input int n_expected);
        int errs;
        int n;
        n = result_count - result_mark;
        if (n != n_expected) begin
            $display("%s: %0d results seen but %0d frames sent", name, n, n_expected);
            err_count++;
        end
        errs = err_count - err_mark;
        if (errs == 0) begin
            test_pass++;
            $display("%s: PASS (%0d results)", name, n);
        end else begin
            test_fail++;
            $display("%s: FAIL (%0d errors)", name, errs);
        end
        err_mark = err_count;
        result_mark = result_count;
    endtask

endmodule

// File: verif/tb_stage3_top.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module tb_stage3_top;

    localparam int BEATS   = `ST3_MAP_W * `ST3_MAP_H;
    localparam int PW      = `ST3_MAP_W / 2;
    localparam int MAX_GAP = 3;
    // Full frames of all tests plus the ones around the reset
    localparam int N_FRAMES     = 1 + 20 + 20 + 1 + `ST3_CO + 3;
    localparam int LIMIT_CYCLES = N_FRAMES * BEATS * (MAX_GAP + 1) + 100;

    logic                         clk = 1'b0;
    logic                         reset_n;
    logic                         relu_valid;
    cnn_data_pkg::pixel_vec_t     relu;
    logic                         dut_valid;
    cnn_class_pkg::class_result_t dut_result;

    logic [31:0]              lfsr = 32'h565f;
    cnn_data_pkg::pixel_vec_t frame [BEATS];

    always #4 clk = ~clk;

    stage3_top_cnn u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_relu_valid (relu_valid),
        .i_relu       (relu),
        .o_valid      (dut_valid),
        .o_result     (dut_result)
    );

    tb_checker u_chk (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_relu_valid (relu_valid),
        .i_relu       (relu),
        .i_dut_valid  (dut_valid),
        .i_dut_result (dut_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < BEATS; i++) begin
            r = rand_bits(24);
            frame[i] = r[23:0];
        end
    endtask

    // Only one pixel of pooled position p is nonzero
    task automatic fill_position(input int p);
        logic [31:0] r;
        for (int i = 0; i < BEATS; i++) begin
            frame[i] = '0;
        end
        for (int ch = 0; ch < `ST3_CI; ch++) begin
            r = rand_bits(8);
            frame[2 * (p / PW) * `ST3_MAP_W + 2 * (p % PW)].ch[ch] = r[7:0] | 8'h01;
        end
    endtask

    // Column p where class cls has the single largest positive weight
    function automatic int pick_position(input int cls);
        int ok;
        for (int p = 0; p < `ST3_POS; p++) begin
            ok = (u_chk.w_model[cls][p] > 0);
            for (int c = 0; c < `ST3_CO; c++) begin
                if (c != cls && u_chk.w_model[c][p] >= u_chk.w_model[cls][p]) begin
                    ok = 0;
                end
            end
            if (ok != 0) begin
                return p;
            end
        end
        return -1;
    endfunction

    task automatic send_beats(input int n, input int max_gap);
        logic [31:0] gap;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            relu_valid <= 1'b1;
            relu       <= frame[i];
            if (max_gap > 0) begin
                gap = rand_bits(2) % (max_gap + 1);
                repeat (gap) begin
                    @(posedge clk);
                    relu_valid <= 1'b0;
                end
            end
        end
    endtask

    // Idle input, wait for every expected result, then a few quiet cycles
    task automatic drain();
        @(posedge clk);
        relu_valid <= 1'b0;
        @(negedge clk);
        while (u_chk.outstanding != 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int pos;
        int n_exp;
        reset_n    = 1'b0;
        relu_valid = 1'b0;
        relu       = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        fill_random();
        send_beats(BEATS, 0);
        drain();
        u_chk.end_test("single frame", 1);

        repeat (20) begin
            fill_random();
            send_beats(BEATS, 0);
        end
        drain();
        u_chk.end_test("back-to-back frames", 20);

        repeat (20) begin
            fill_random();
            send_beats(BEATS, MAX_GAP);
        end
        drain();
        u_chk.end_test("random gaps", 20);

        // All-zero frame ties every score
        for (int i = 0; i < BEATS; i++) begin
            frame[i] = '0;
        end
        send_beats(BEATS, 0);
        n_exp = 1;
        for (int c = 0; c < `ST3_CO; c++) begin
            pos = pick_position(c);
            if (pos < 0) begin
                u_chk.report_failure($sformatf("No pooled position favours class %0d", c));
            end else begin
                fill_position(pos);
                send_beats(BEATS, 0);
                n_exp++;
            end
        end
        drain();
        u_chk.end_test("ties and signs", n_exp);

        // Reset inside a new frame while the previous result is still in flight
        fill_random();
        send_beats(BEATS, 0);
        fill_random();
        send_beats(1, 0);
        @(posedge clk);
        relu_valid <= 1'b0;
        reset_n    <= 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        repeat (6) @(posedge clk);
        fill_random();
        send_beats(BEATS, 0);
        drain();
        u_chk.end_test("reset mid-frame", 1);

        $display("Summary: %0d passed, %0d failed",
                 u_chk.test_pass, u_chk.test_fail);
        if (u_chk.test_fail == 0 && u_chk.err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
